// File: sources.f
tile_cfg_pkg.sv
tile_mem_pkg.sv
tile_spm_bank.sv
tile_bank_xbar.sv
tile_addr_demux.sv
tile_top.sv
tb_clk_gen.sv
tile_sva.sv
tile_tb.sv

// File: tb_clk_gen.sv
// Clock and reset source of the tile testbench
// 4 ns clock, reset held low for the first 16 rising edges
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin : gen
    clk_o  = 1'b0;
    rst_no = 1'b0;
    fork
      forever #2 clk_o = ~clk_o;         // 4 ns period
      begin
        repeat (16) @(posedge clk_o);
        rst_no <= 1'b1;                  // Release in step with the clock
      end
    join_none
  end

endmodule

// File: tile_addr_demux.sv
// Address demux of the core data port
// Sends each access to the L1 path, the external L2 port or the error responder
// by address window. One transaction may be outstanding at a time
`timescale 1ns/1ns

module tile_addr_demux
  import tile_cfg_pkg::*;
  import tile_mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  mem_req_t core_req_i,   // Qualified core request
  output mem_rsp_t core_rsp_o,
  output mem_req_t l1_req_o,     // Towards the bank crossbar
  input  mem_rsp_t l1_rsp_i,
  output mem_req_t l2_req_o,     // External L2 port
  input  mem_rsp_t l2_rsp_i
);

  demux_tgt_e tgt_q;       // Target of the outstanding access
  demux_tgt_e tgt_d;
  logic       hit_l1;
  logic       hit_l2;
  logic       idle;        // Nothing outstanding
  logic       accept;      // Core request taken this cycle

  // Windows do not overlap
  assign hit_l1 = (core_req_i.addr >= L1_BASE) && (core_req_i.addr <= L1_END);
  assign hit_l2 = (core_req_i.addr >= L2_BASE) && (core_req_i.addr <= L2_END);
  assign idle   = (tgt_q == TGT_NONE);

  // Fields pass through, only the strobe is steered
  always_comb begin : route_req
    l1_req_o     = core_req_i;
    l1_req_o.req = core_req_i.req && idle && hit_l1;
    l2_req_o     = core_req_i;
    l2_req_o.req = core_req_i.req && idle && hit_l2;
  end

  always_comb begin : next_tgt
    accept = 1'b0;
    tgt_d  = tgt_q;
    if (idle) begin
      if (l1_req_o.req && l1_rsp_i.gnt) begin
        accept = 1'b1;
        tgt_d  = TGT_L1;
      end else if (l2_req_o.req && l2_rsp_i.gnt) begin
        accept = 1'b1;
        tgt_d  = TGT_L2;
      end else if (core_req_i.req && !hit_l1 && !hit_l2) begin
        accept = 1'b1;          // Unmapped is taken at once
        tgt_d  = TGT_ERR;
      end
    end else if (core_rsp_o.rvalid) begin
      tgt_d = TGT_NONE;         // Free again after the response
    end
  end

  always_comb begin : steer_rsp
    core_rsp_o     = '0;
    core_rsp_o.gnt = accept;
    case (tgt_q)
      TGT_L1: begin
        core_rsp_o.rvalid = l1_rsp_i.rvalid;
        core_rsp_o.rdata  = l1_rsp_i.rdata;
        core_rsp_o.err    = l1_rsp_i.err;
      end
      TGT_L2: begin
        core_rsp_o.rvalid = l2_rsp_i.rvalid;  // Variable latency
        core_rsp_o.rdata  = l2_rsp_i.rdata;
        core_rsp_o.err    = l2_rsp_i.err;
      end
      TGT_ERR: begin
        core_rsp_o.rvalid = 1'b1;             // One cycle after acceptance
        core_rsp_o.err    = 1'b1;
      end
      default: begin
        core_rsp_o.rvalid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : tgt_reg
    if (!rst_ni) begin
      tgt_q <= TGT_NONE;
    end else begin
      tgt_q <= tgt_d;
    end
  end

endmodule

// File: tile_bank_xbar.sv
// Scratchpad crossbar between the two requesters and the banks
// The accelerator port wins a bank over the core L1 path in the same cycle,
// different banks are served in parallel. Responses follow one cycle after gnt
`timescale 1ns/1ns

module tile_bank_xbar
  import tile_cfg_pkg::*;
  import tile_mem_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  mem_req_t                core_req_i,    // Core path, L1 addresses only
  output mem_rsp_t                core_rsp_o,
  input  acc_req_t                acc_req_i,     // Accelerator port
  output mem_rsp_t                acc_rsp_o,
  output bank_req_t [N_BANKS-1:0] bank_req_o,    // One request per bank
  input  data_t     [N_BANKS-1:0] bank_rdata_i   // Registered bank read words
);

  spm_addr_t core_off;      // Core offset inside L1
  bank_idx_t core_bank;
  word_idx_t core_word;
  bank_idx_t acc_bank;
  word_idx_t acc_word;

  logic      core_gnt;
  logic      acc_gnt;
  logic      conflict;      // Both ports hit the same bank

  logic      core_vld_q;    // Core access accepted last cycle
  bank_idx_t core_bank_q;   // Bank that served it
  logic      acc_vld_q;
  bank_idx_t acc_bank_q;

  // Word interleaved decode
  assign core_off  = core_req_i.addr[SPM_ADDR_W-1:0];
  assign core_bank = core_off[BANK_LSB +: BANK_IDX_W];
  assign core_word = core_off[WORD_LSB +: WORD_IDX_W];
  assign acc_bank  = acc_req_i.addr[BANK_LSB +: BANK_IDX_W];
  assign acc_word  = acc_req_i.addr[WORD_LSB +: WORD_IDX_W];

  // Fixed priority, accelerator first
  assign conflict = acc_req_i.req && core_req_i.req && (acc_bank == core_bank);
  assign acc_gnt  = acc_req_i.req;             // Never blocked
  assign core_gnt = core_req_i.req && !conflict; // Waits on a bank clash

  always_comb begin : bank_drive
    for (int b = 0; b < N_BANKS; b++) begin
      bank_req_o[b] = '0;                          // Idle bank
      if (acc_req_i.req && (acc_bank == bank_idx_t'(b))) begin
        bank_req_o[b] = '{
          en:    1'b1,
          we:    acc_req_i.we,
          be:    acc_req_i.be,
          word:  acc_word,
          wdata: acc_req_i.wdata
        };
      end else if (core_req_i.req && (core_bank == bank_idx_t'(b))) begin
        bank_req_o[b] = '{
          en:    1'b1,
          we:    core_req_i.we,
          be:    core_req_i.be,
          word:  core_word,
          wdata: core_req_i.wdata
        };
      end
    end
  end

  // Track the accepted access of each port for its response
  always_ff @(posedge clk_i or negedge rst_ni) begin : rsp_track
    if (!rst_ni) begin
      core_vld_q  <= 1'b0;
      core_bank_q <= '0;
      acc_vld_q   <= 1'b0;
      acc_bank_q  <= '0;
    end else begin
      core_vld_q <= core_gnt;
      acc_vld_q  <= acc_gnt;
      if (core_gnt) begin
        core_bank_q <= core_bank;
      end
      if (acc_gnt) begin
        acc_bank_q <= acc_bank;
      end
    end
  end

  assign core_rsp_o = '{
    gnt:    core_gnt,
    rvalid: core_vld_q,
    rdata:  bank_rdata_i[core_bank_q],  // Word read in the accepting cycle
    err:    1'b0
  };

  assign acc_rsp_o = '{
    gnt:    acc_gnt,
    rvalid: acc_vld_q,
    rdata:  bank_rdata_i[acc_bank_q],
    err:    1'b0
  };

endmodule

// File: tile_cfg_pkg.sv
// Configuration of the accelerator tile memory system
// Address map, scratchpad geometry and the width types shared by RTL and testbench
// Import with a wildcard where the types or the map are needed
package tile_cfg_pkg;

  localparam int unsigned ADDR_W       = 32;             // Byte address width
  localparam int unsigned DATA_W       = 32;             // Data word width
  localparam int unsigned BE_W         = DATA_W / 8;     // Byte enables per word
  localparam int unsigned N_BANKS      = 4;              // Scratchpad banks
  localparam int unsigned N_WORDS_BANK = 256;            // Rows per bank

  localparam int unsigned BYTE_OFF_W   = $clog2(BE_W);          // Byte inside a word
  localparam int unsigned BANK_IDX_W   = $clog2(N_BANKS);       // Bank select bits
  localparam int unsigned WORD_IDX_W   = $clog2(N_WORDS_BANK);  // Row select bits
  localparam int unsigned SPM_ADDR_W   = WORD_IDX_W + BANK_IDX_W + BYTE_OFF_W; // L1 offset

  typedef logic [ADDR_W-1:0]     addr_t;      // Byte address
  typedef logic [DATA_W-1:0]     data_t;      // Data word
  typedef logic [BE_W-1:0]       be_t;        // Byte enables
  typedef logic [SPM_ADDR_W-1:0] spm_addr_t;  // Byte offset inside L1
  typedef logic [BANK_IDX_W-1:0] bank_idx_t;  // Offset bits 3:2
  typedef logic [WORD_IDX_W-1:0] word_idx_t;  // Offset bits 11:4

  // L1 scratchpad window, 4 KiB
  localparam addr_t L1_BASE = 32'h1000_0000;
  localparam addr_t L1_END  = 32'h1000_0FFF;

  // External L2 window, 1 MiB
  localparam addr_t L2_BASE = 32'h1C00_0000;
  localparam addr_t L2_END  = 32'h1C0F_FFFF;

  // Word interleaving puts the bank right above the byte offset
  localparam int unsigned BANK_LSB = BYTE_OFF_W;              // Lowest bank bit
  localparam int unsigned WORD_LSB = BYTE_OFF_W + BANK_IDX_W; // Lowest row bit

endpackage

// File: tile_mem_pkg.sv
// Transaction types of the tile memory system
// Request and response structs of the core, accelerator and L2 ports,
// the bank-side request and the state encoding of the address demux
package tile_mem_pkg;

  import tile_cfg_pkg::*;

  // Core and L2 side request, fields held until gnt
  typedef struct packed {
    logic  req;    // Request strobe
    addr_t addr;   // Full byte address
    logic  we;     // Write when set
    be_t   be;     // Byte enables
    data_t wdata;  // Write data
  } mem_req_t;

  // Response shared by all ports
  typedef struct packed {
    logic  gnt;     // Request accepted this cycle
    logic  rvalid;  // Response valid
    data_t rdata;   // Read data
    logic  err;     // Error on the transaction
  } mem_rsp_t;

  // Accelerator request, addresses only the scratchpad
  typedef struct packed {
    logic      req;
    spm_addr_t addr;   // L1 byte offset
    logic      we;
    be_t       be;
    data_t     wdata;
  } acc_req_t;

  // One bank access per cycle
  typedef struct packed {
    logic      en;     // Access strobe
    logic      we;     // Write when set
    be_t       be;
    word_idx_t word;   // Row in the bank
    data_t     wdata;
  } bank_req_t;

  // Target of the outstanding core transaction
  typedef enum logic [1:0] {
    TGT_NONE = 2'd0,  // Idle
    TGT_L1   = 2'd1,  // Scratchpad
    TGT_L2   = 2'd2,  // External L2
    TGT_ERR  = 2'd3   // Unmapped
  } demux_tgt_e;

endpackage

// File: tile_spm_bank.sv
// Single scratchpad bank
// Byte-enable writes and a registered read port, data valid the cycle after en
// Four of these are interleaved by word behind the bank crossbar
`timescale 1ns/1ns

module tile_spm_bank
  import tile_cfg_pkg::*;
  import tile_mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  bank_req_t bank_req_i,  // Access from the crossbar
  output data_t     rdata_o      // Registered read word
);

  data_t mem [N_WORDS_BANK];     // Storage array

  // Contents start cleared in simulation
  initial begin : clear_mem
    for (int i = 0; i < N_WORDS_BANK; i++) begin
      mem[i] = '0;
    end
  end

  always @(posedge clk_i) begin : write_port
    if (bank_req_i.en && bank_req_i.we) begin
      for (int i = 0; i < BE_W; i++) begin
        if (bank_req_i.be[i]) begin
          mem[bank_req_i.word][8*i +: 8] <= bank_req_i.wdata[8*i +: 8]; // Only enabled lanes
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : read_port
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (bank_req_i.en && !bank_req_i.we) begin
      rdata_o <= mem[bank_req_i.word];  // Old word kept on writes
    end
  end

endmodule

// File: tile_sva.sv
// Protocol assertions on the tile top-level ports
// Bound into tile_top by the testbench, reports through failing assertions only
`timescale 1ns/1ns

module tile_sva
  import tile_cfg_pkg::*;
  import tile_mem_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input logic     tile_enable_i,
  input mem_req_t core_req_i,
  input mem_rsp_t core_rsp_o,
  input acc_req_t acc_req_i,
  input mem_rsp_t acc_rsp_o
);

  logic outstanding;  // Core access accepted, response not yet seen

  always_ff @(posedge clk_i or negedge rst_ni) begin : track_core
    if (!rst_ni) begin
      outstanding <= 1'b0;
    end else if (core_req_i.req && core_rsp_o.gnt) begin
      outstanding <= 1'b1;
    end else if (core_rsp_o.rvalid) begin
      outstanding <= 1'b0;  // Cleared after the rvalid cycle
    end
  end

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (core_rsp_o.gnt |-> core_req_i.req) and (acc_rsp_o.gnt |-> acc_req_i.req))
    else $error("gnt without req");

  acc_rvalid_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_req_i.req && acc_rsp_o.gnt |=> acc_rsp_o.rvalid)
    else $error("accelerator rvalid missing");

  core_single_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outstanding |-> !core_rsp_o.gnt)
    else $error("second core gnt while outstanding");

  no_gnt_when_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !tile_enable_i |=> !(core_rsp_o.gnt || acc_rsp_o.gnt))
    else $error("gnt while tile disabled");

endmodule

// File: tile_tb.sv
// Testbench of the tile memory system
// Runs enable and arbitration sequences, then a stimulus table through both ports,
// with a byte-enable model of L1 and a random-latency L2 responder
`timescale 1ns/1ns

module tile_tb
  import tile_cfg_pkg::*;
  import tile_mem_pkg::*;
();

  typedef struct packed {
    logic [2:0] test;       // Test number of the row
    logic       acc;        // Accelerator port when set
    logic       we;
    addr_t      addr;       // Full address, offset used on the accelerator port
    be_t        be;
    data_t      wdata;
    data_t      exp_rdata;  // Used for reads outside L1
    logic       exp_err;
  } row_t;

  localparam int TMO = 50;                      // Cycles per wait
  localparam addr_t L2_ERR_ADDR = 32'h1C00_0100; // Responder flags this one

  logic clk_i, rst_ni, tile_enable_i;
  mem_req_t core_req, l2_req;
  acc_req_t acc_req;
  mem_rsp_t core_rsp, acc_rsp, l2_rsp;
  row_t rows[$];
  data_t model [1024];                          // L1 words by offset bits 11:2
  int errs, test_errs, n_tests, n_fail, l2_reqs;
  int unsigned lcg_state = 71237;
  logic l2_busy, l2_rv, l2_err;
  int l2_cnt;
  addr_t l2_addr;
  data_t l2_rdata;

  tb_clk_gen tb_clk_gen_inst (.clk_o(clk_i), .rst_no(rst_ni));

  tile_top tile_top_inst (
    .clk_i(clk_i), .rst_ni(rst_ni), .tile_enable_i(tile_enable_i),
    .core_req_i(core_req), .core_rsp_o(core_rsp), .acc_req_i(acc_req),
    .acc_rsp_o(acc_rsp), .l2_req_o(l2_req), .l2_rsp_i(l2_rsp)
  );

  bind tile_top tile_sva tile_sva_inst (.*);

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic data_t l2_data(addr_t a);
    return {a[15:0], ~a[15:0]};                 // Address pattern of the L2 model
  endfunction

  // L2 responder, one access at a time
  always_comb begin : l2_rsp_drive
    l2_rsp = '{gnt: l2_req.req && !l2_busy, rvalid: l2_rv,
               rdata: l2_rdata, err: l2_err};
  end

  always @(posedge clk_i or negedge rst_ni) begin : l2_model
    if (!rst_ni) begin
      l2_busy <= 1'b0;
      l2_rv   <= 1'b0;
    end else begin
      l2_rv <= 1'b0;
      if (l2_req.req && !l2_busy) begin
        l2_busy <= 1'b1;
        l2_addr <= l2_req.addr;
        l2_cnt  <= (lcg_next() >> 16) % 5;      // 0 to 4 extra cycles
        l2_reqs <= l2_reqs + 1;
      end else if (l2_busy && l2_cnt == 0) begin
        l2_busy  <= 1'b0;
        l2_rv    <= 1'b1;
        l2_rdata <= l2_data(l2_addr);
        l2_err   <= (l2_addr == L2_ERR_ADDR);
      end else if (l2_busy) begin
        l2_cnt <= l2_cnt - 1;
      end
    end
  end

  task automatic check(string name, logic [79:0] got, logic [79:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s exp=%h got=%h", $time, name, exp, got);
      test_errs++;
    end
  endtask

  task automatic end_test(int num, string what);
    $display("test %0d %s: %s", num, what, test_errs ? "FAIL" : "ok");
    n_tests++;
    if (test_errs != 0) n_fail++;
    errs += test_errs;
    test_errs = 0;
  endtask

  function automatic logic in_l1(row_t r);
    return r.acc || (r.addr >= L1_BASE && r.addr <= L1_END);
  endfunction

  function automatic logic in_l2(row_t r);
    return !r.acc && r.addr >= L2_BASE && r.addr <= L2_END;
  endfunction

  // One access through its port, latency counted from the accepting edge
  task automatic access(row_t r, output data_t rdata, output logic err, output int lat);
    int n;
    @(posedge clk_i);
    if (r.acc) acc_req <= '{1'b1, r.addr[SPM_ADDR_W-1:0], r.we, r.be, r.wdata};
    else core_req <= '{1'b1, r.addr, r.we, r.be, r.wdata};
    for (n = 0; n < TMO; n++) begin
      @(negedge clk_i);
      if (r.acc ? acc_rsp.gnt : core_rsp.gnt) break;
    end
    if (n == TMO) begin
      $display("no grant for address %h", r.addr);
      test_errs++;
    end
    if (in_l2(r))
      check("l2_req_o", l2_req, {1'b1, r.addr, r.we, r.be, r.wdata});
    @(posedge clk_i);
    acc_req.req  <= 1'b0;
    core_req.req <= 1'b0;
    for (lat = 1; lat <= TMO; lat++) begin
      @(negedge clk_i);
      if (r.acc ? acc_rsp.rvalid : core_rsp.rvalid) break;
    end
    if (lat > TMO) begin
      $display("no response for address %h", r.addr);
      test_errs++;
    end
    rdata = r.acc ? acc_rsp.rdata : core_rsp.rdata;
    err   = r.acc ? acc_rsp.err : core_rsp.err;
  endtask

  task automatic run_row(row_t r);
    data_t rdata, exp;
    logic err;
    int lat, l2_before;
    l2_before = l2_reqs;
    exp = in_l1(r) ? model[r.addr[11:2]] : r.exp_rdata;
    access(r, rdata, err, lat);
    if (!r.we) check("rdata", rdata, exp);
    check("err", err, r.exp_err);
    if (!in_l2(r)) check("rvalid latency", lat, 1);  // L1 and unmapped answer at once
    if (in_l1(r) && r.we) begin
      for (int i = 0; i < BE_W; i++)
        if (r.be[i]) model[r.addr[11:2]][8*i +: 8] = r.wdata[8*i +: 8];
    end
    check("l2 request count", l2_reqs - l2_before, in_l2(r) ? 1 : 0);
  endtask

  // Core L2 read with an L1 read held behind it, the second waits out the first
  task automatic queue_behind_l2();
    int n;
    @(posedge clk_i);
    core_req <= '{1'b1, 32'h1C00_0200, 1'b0, 4'hF, 32'h0};
    for (n = 0; n < TMO; n++) begin
      @(negedge clk_i);
      if (core_rsp.gnt) break;
    end
    if (n == TMO) begin
      $display("L2 read never granted");
      test_errs++;
    end
    @(posedge clk_i);
    core_req <= '{1'b1, 32'h1000_0010, 1'b0, 4'hF, 32'h0};  // Back-pressured request
    for (n = 0; n < TMO; n++) begin
      @(negedge clk_i);
      check("gnt while outstanding", core_rsp.gnt, 0);      // Also in the rvalid cycle
      if (core_rsp.rvalid) break;
    end
    if (n == TMO) begin
      $display("no response to the L2 read");
      test_errs++;
    end
    check("l2 rdata", core_rsp.rdata, l2_data(32'h1C00_0200));
    for (n = 0; n < TMO; n++) begin
      @(negedge clk_i);
      if (core_rsp.gnt) break;
    end
    if (n == TMO) begin
      $display("held request never granted");
      test_errs++;
    end
    @(posedge clk_i);
    core_req.req <= 1'b0;
    @(negedge clk_i);
    check("core rvalid", core_rsp.rvalid, 1);
    check("core rdata", core_rsp.rdata, model[4]);
  endtask

  task automatic add(logic [2:0] t, logic acc, logic we, addr_t a, be_t be, data_t wd,
                     data_t exp, logic err);
    rows.push_back(row_t'{t, acc, we, a, be, wd, exp, err});
  endtask

  initial begin : watchdog
    #200000;
    $display("simulation timed out");
    $display("Test failed");
    $finish;
  end

  initial begin : main
    int n, cur;
    tile_enable_i = 1'b0;
    core_req = '0;
    acc_req  = '0;
    l2_reqs  = 0;
    for (int i = 0; i < 1024; i++) model[i] = '0;
    add(2, 0, 1, 32'h1000_0010, 4'hF, 32'h1122_3344, 0, 0);
    add(2, 0, 1, 32'h1000_0010, 4'h5, 32'hAABB_CCDD, 0, 0);  // Lanes 0 and 2
    add(2, 0, 0, 32'h1000_0010, 4'hF, 0, 0, 0);
    add(2, 0, 1, 32'h1000_0024, 4'hC, 32'hDEAD_BEEF, 0, 0);
    add(2, 0, 0, 32'h1000_0024, 4'hF, 0, 0, 0);
    add(2, 0, 0, 32'h1000_0FFC, 4'hF, 0, 0, 0);
    add(3, 1, 1, 32'h0000_0030, 4'hF, 32'hCAFE_F00D, 0, 0);
    add(3, 0, 0, 32'h1000_0030, 4'hF, 0, 0, 0);
    add(3, 0, 1, 32'h1000_0034, 4'h3, 32'h0000_1234, 0, 0);
    add(3, 1, 0, 32'h0000_0034, 4'hF, 0, 0, 0);
    add(5, 0, 0, 32'h1C00_0040, 4'hF, 0, l2_data(32'h1C00_0040), 0);
    add(5, 0, 1, 32'h1C00_0080, 4'h6, 32'h5555_AAAA, 0, 0);
    add(5, 0, 0, L2_ERR_ADDR, 4'hF, 0, l2_data(L2_ERR_ADDR), 1);
    add(5, 0, 0, 32'h1000_0080, 4'hF, 0, 0, 0);              // Same offset as the L2 write
    add(6, 0, 0, 32'h2000_0000, 4'hF, 0, 0, 1);
    add(6, 0, 1, 32'h1000_1000, 4'hF, 32'hFFFF_FFFF, 0, 1);   // Just past L1
    add(6, 0, 0, 32'h1000_0000, 4'hF, 0, 0, 0);
    for (n = 0; n < TMO && !rst_ni; n++) @(posedge clk_i);
    if (!rst_ni) begin
      $display("reset never released");
      test_errs++;
    end

    // Test 1, requests held while the tile is off
    @(posedge clk_i);
    core_req <= '{1'b1, 32'h1000_0004, 1'b0, 4'hF, 32'h0};
    acc_req  <= '{1'b1, 12'h008, 1'b0, 4'hF, 32'h0};
    for (n = 0; n < 20; n++) begin
      @(negedge clk_i);
      if (core_rsp.gnt || acc_rsp.gnt) check("gnt while off", 1, 0);
    end
    @(posedge clk_i);
    tile_enable_i <= 1'b1;
    for (n = 0; n < TMO && !(core_rsp.gnt && acc_rsp.gnt); n++) @(negedge clk_i);
    if (n == TMO) begin
      $display("no grant after enable");
      test_errs++;
    end
    @(posedge clk_i);
    core_req.req <= 1'b0;
    acc_req.req  <= 1'b0;
    @(negedge clk_i);
    check("core rvalid", core_rsp.rvalid, 1);
    check("acc rvalid", acc_rsp.rvalid, 1);
    check("core rdata", core_rsp.rdata, 0);
    end_test(1, "enable");

    cur = rows[0].test;
    foreach (rows[i]) begin
      run_row(rows[i]);
      if (i == rows.size() - 1 || rows[i+1].test != cur) begin
        if (cur == 5) queue_behind_l2();
        end_test(cur, cur == 2 ? "core L1" : cur == 3 ? "shared L1" :
                      cur == 5 ? "L2 route" : "unmapped");
        if (cur == 3) begin
          // Test 4, same bank first, then different banks
          @(posedge clk_i);
          acc_req  <= '{1'b1, 12'h040, 1'b1, 4'hF, 32'h5A5A_1234};
          core_req <= '{1'b1, 32'h1000_0040, 1'b0, 4'hF, 32'h0};
          @(negedge clk_i);
          check("acc gnt", acc_rsp.gnt, 1);
          check("core gnt", core_rsp.gnt, 0);
          @(posedge clk_i);
          acc_req.req <= 1'b0;
          model[16] = 32'h5A5A_1234;
          for (n = 0; n < TMO; n++) begin
            @(negedge clk_i);
            if (core_rsp.gnt) break;
          end
          if (n == TMO) begin
            $display("core never granted after the clash");
            test_errs++;
          end
          @(posedge clk_i);
          core_req.req <= 1'b0;
          @(negedge clk_i);
          check("core rvalid", core_rsp.rvalid, 1);
          check("core rdata", core_rsp.rdata, model[16]);
          @(posedge clk_i);
          acc_req  <= '{1'b1, 12'h044, 1'b0, 4'hF, 32'h0};
          core_req <= '{1'b1, 32'h1000_0048, 1'b0, 4'hF, 32'h0};
          @(negedge clk_i);
          check("acc gnt", acc_rsp.gnt, 1);
          check("core gnt", core_rsp.gnt, 1);
          @(posedge clk_i);
          acc_req.req  <= 1'b0;
          core_req.req <= 1'b0;
          @(negedge clk_i);
          check("acc rvalid", acc_rsp.rvalid, 1);
          check("core rvalid", core_rsp.rvalid, 1);
          end_test(4, "arbitration");
        end
        if (i < rows.size() - 1) cur = rows[i+1].test;
      end
    end

    $display("tests %0d, failed %0d, errors %0d", n_tests, n_fail, errs);
    if (errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tile_top.sv
// Top level of the accelerator tile memory system
// Core data port with L1, L2 and unmapped routing, accelerator port into L1,
// and a four bank scratchpad. No traffic passes before the tile is enabled
`timescale 1ns/1ns

module tile_top
  import tile_cfg_pkg::*;
  import tile_mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     tile_enable_i,  // Switches the tile on
  input  mem_req_t core_req_i,     // Core data port
  output mem_rsp_t core_rsp_o,
  input  acc_req_t acc_req_i,      // Accelerator port
  output mem_rsp_t acc_rsp_o,
  output mem_req_t l2_req_o,       // External L2
  input  mem_rsp_t l2_rsp_i
);

  logic                    tile_en;      // Registered enable
  mem_req_t                core_req_en;  // Core request after qualification
  acc_req_t                acc_req_en;
  mem_req_t                l1_req;       // Demux to crossbar
  mem_rsp_t                l1_rsp;
  bank_req_t [N_BANKS-1:0] bank_req;
  data_t     [N_BANKS-1:0] bank_rdata;

  always_ff @(posedge clk_i or negedge rst_ni) begin : tile_en_reg
    if (!rst_ni) begin
      tile_en <= 1'b0;           // Off after reset
    end else begin
      tile_en <= tile_enable_i;
    end
  end

  // Strobes held off while the tile is off
  always_comb begin : qualify_req
    core_req_en     = core_req_i;
    core_req_en.req = core_req_i.req && tile_en;
    acc_req_en      = acc_req_i;
    acc_req_en.req  = acc_req_i.req && tile_en;
  end

  tile_addr_demux tile_addr_demux_inst (
    .clk_i      ( clk_i       ),
    .rst_ni     ( rst_ni      ),
    .core_req_i ( core_req_en ),
    .core_rsp_o ( core_rsp_o  ),
    .l1_req_o   ( l1_req      ),
    .l1_rsp_i   ( l1_rsp      ),
    .l2_req_o   ( l2_req_o    ),
    .l2_rsp_i   ( l2_rsp_i    )
  );

  tile_bank_xbar tile_bank_xbar_inst (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .core_req_i   ( l1_req     ),
    .core_rsp_o   ( l1_rsp     ),
    .acc_req_i    ( acc_req_en ),
    .acc_rsp_o    ( acc_rsp_o  ),
    .bank_req_o   ( bank_req   ),
    .bank_rdata_i ( bank_rdata )
  );

  // Word interleaved scratchpad
  for (genvar b = 0; b < N_BANKS; b++) begin : gen_bank
    tile_spm_bank tile_spm_bank_inst (
      .clk_i      ( clk_i         ),
      .rst_ni     ( rst_ni        ),
      .bank_req_i ( bank_req[b]   ),
      .rdata_o    ( bank_rdata[b] )
    );
  end

endmodule
